//--- source/decode_pkg.sv
// Decode stage package
// RV32I widths, major opcodes, operation and format encodings, stage structs
package decode_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int TAG_W      = 3;

    //////////////////////////////
    // Major opcodes
    //////////////////////////////
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    //////////////////////////////
    // Decoded operation
    //////////////////////////////
    // NOP must stay at zero, bubbles and reset rely on it
    typedef enum logic [5:0] {
        NOP    = 6'h00, LUI    = 6'h01, ADD    = 6'h02, SUB    = 6'h03,
        XOR    = 6'h04, OR     = 6'h05, AND    = 6'h06, SLL    = 6'h07,
        SRL    = 6'h08, SRA    = 6'h09, SLT    = 6'h0a, SLTU   = 6'h0b,
        JAL    = 6'h0c, JALR   = 6'h0d, BEQ    = 6'h0e, BNE    = 6'h0f,
        BLT    = 6'h10, BGE    = 6'h11, BLTU   = 6'h12, BGEU   = 6'h13,
        LB     = 6'h14, LBU    = 6'h15, LH     = 6'h16, LHU    = 6'h17,
        LW     = 6'h18, SB     = 6'h19, SH     = 6'h1a, SW     = 6'h1b,
        ECALL  = 6'h1c, EBREAK = 6'h1d, SRET   = 6'h1e, MRET   = 6'h1f,
        WFI    = 6'h20, CSRRW  = 6'h21, CSRRS  = 6'h22, CSRRC  = 6'h23,
        CSRRWI = 6'h24, CSRRSI = 6'h25, CSRRCI = 6'h26, INVALID = 6'h3f
    } op_e;

    typedef enum logic [2:0] {
        R_TYPE = 3'd0,
        I_TYPE = 3'd1,
        S_TYPE = 3'd2,
        B_TYPE = 3'd3,
        U_TYPE = 3'd4,
        J_TYPE = 3'd5
    } format_e;

    //////////////////////////////
    // Stage structs
    //////////////////////////////
    typedef struct packed {
        op_e     op;
        format_e format;
        logic    use_rs1;
        logic    use_rs2;
        logic    is_load;
        logic    is_store;
        logic    illegal;
    } decoded_t;

    typedef struct packed {
        logic [XLEN-1:0] first;
        logic [XLEN-1:0] second;
        logic [XLEN-1:0] third;
    } operands_t;

    // Payload handed to execute
    typedef struct packed {
        op_e                   op;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       first;
        logic [XLEN-1:0]       second;
        logic [XLEN-1:0]       third;
        logic [XLEN-1:0]       pc;
        logic [TAG_W-1:0]      tag;
        logic                  illegal;
        logic                  misaligned;
        logic                  access_fault;
    } issue_t;

endpackage

//--- source/op_decoder.sv
// Operation decoder
// Maps opcode and funct fields to operation, format, register use and illegal flag
module op_decoder
    import decode_pkg::*;
(
    input  logic [XLEN-1:0] instruction_i,
    output decoded_t        decoded_o
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] funct12;
    logic        no_regs;

    assign opcode  = instruction_i[6:0];
    assign funct3  = instruction_i[14:12];
    assign funct7  = instruction_i[31:25];
    assign funct12 = instruction_i[31:20];
    // rs1 and rd both x0, required by the privileged encodings
    assign no_regs = (instruction_i[19:15] == '0) && (instruction_i[11:7] == '0);

    //////////////////////////////
    // Group sub-decoders
    //////////////////////////////
    op_e op_branch, op_load, op_store, op_op_imm, op_op, op_misc_mem, op_system;

    always_comb begin
        unique case (funct3)
            3'b000:  op_branch = BEQ;
            3'b001:  op_branch = BNE;
            3'b100:  op_branch = BLT;
            3'b101:  op_branch = BGE;
            3'b110:  op_branch = BLTU;
            3'b111:  op_branch = BGEU;
            default: op_branch = INVALID;
        endcase
    end

    always_comb begin
        unique case (funct3)
            3'b000:  op_load = LB;
            3'b001:  op_load = LH;
            3'b010:  op_load = LW;
            3'b100:  op_load = LBU;
            3'b101:  op_load = LHU;
            default: op_load = INVALID;
        endcase
    end

    always_comb begin
        unique case (funct3)
            3'b000:  op_store = SB;
            3'b001:  op_store = SH;
            3'b010:  op_store = SW;
            default: op_store = INVALID;
        endcase
    end

    // Shift immediates check funct7, the rest ignore it
    always_comb begin
        unique case ({funct7, funct3}) inside
            10'b???????000: op_op_imm = ADD;
            10'b0000000001: op_op_imm = SLL;
            10'b???????010: op_op_imm = SLT;
            10'b???????011: op_op_imm = SLTU;
            10'b???????100: op_op_imm = XOR;
            10'b0000000101: op_op_imm = SRL;
            10'b0100000101: op_op_imm = SRA;
            10'b???????110: op_op_imm = OR;
            10'b???????111: op_op_imm = AND;
            default:        op_op_imm = INVALID;
        endcase
    end

    // funct7 of 0000001 (MUL/DIV group) lands in default
    always_comb begin
        unique case ({funct7, funct3})
            10'b0000000000: op_op = ADD;
            10'b0100000000: op_op = SUB;
            10'b0000000001: op_op = SLL;
            10'b0000000010: op_op = SLT;
            10'b0000000011: op_op = SLTU;
            10'b0000000100: op_op = XOR;
            10'b0000000101: op_op = SRL;
            10'b0100000101: op_op = SRA;
            10'b0000000110: op_op = OR;
            10'b0000000111: op_op = AND;
            default:        op_op = INVALID;
        endcase
    end

    // FENCE runs as a NOP
    assign op_misc_mem = (funct3 == 3'b000) ? NOP : INVALID;

    always_comb begin
        op_system = INVALID;
        unique case (funct3)
            3'b000: begin
                if (no_regs) begin
                    unique case (funct12)
                        12'h000: op_system = ECALL;
                        12'h001: op_system = EBREAK;
                        12'h102: op_system = SRET;
                        12'h302: op_system = MRET;
                        12'h105: op_system = WFI;
                        default: op_system = INVALID;
                    endcase
                end
            end
            3'b001:  op_system = CSRRW;
            3'b010:  op_system = CSRRS;
            3'b011:  op_system = CSRRC;
            3'b101:  op_system = CSRRWI;
            3'b110:  op_system = CSRRSI;
            3'b111:  op_system = CSRRCI;
            default: op_system = INVALID;
        endcase
    end

    //////////////////////////////
    // Operation and format
    //////////////////////////////
    always_comb begin
        unique case (opcode)
            OPC_LUI:      decoded_o.op = LUI;
            OPC_AUIPC:    decoded_o.op = ADD;
            OPC_JAL:      decoded_o.op = JAL;
            OPC_JALR:     decoded_o.op = JALR;
            OPC_BRANCH:   decoded_o.op = op_branch;
            OPC_LOAD:     decoded_o.op = op_load;
            OPC_STORE:    decoded_o.op = op_store;
            OPC_OP_IMM:   decoded_o.op = op_op_imm;
            OPC_OP:       decoded_o.op = op_op;
            OPC_MISC_MEM: decoded_o.op = op_misc_mem;
            OPC_SYSTEM:   decoded_o.op = op_system;
            default:      decoded_o.op = INVALID;
        endcase
    end

    always_comb begin
        unique case (opcode)
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: decoded_o.format = I_TYPE;
            OPC_STORE:                      decoded_o.format = S_TYPE;
            OPC_BRANCH:                     decoded_o.format = B_TYPE;
            OPC_LUI, OPC_AUIPC:             decoded_o.format = U_TYPE;
            OPC_JAL:                        decoded_o.format = J_TYPE;
            default:                        decoded_o.format = R_TYPE;
        endcase
    end

    // Register use follows the format; CSR immediates still count as reads
    always_comb begin
        unique case (decoded_o.format)
            R_TYPE, B_TYPE, S_TYPE: {decoded_o.use_rs1, decoded_o.use_rs2} = 2'b11;
            I_TYPE:                 {decoded_o.use_rs1, decoded_o.use_rs2} = 2'b10;
            default:                {decoded_o.use_rs1, decoded_o.use_rs2} = 2'b00;
        endcase
    end

    assign decoded_o.is_load  = (opcode == OPC_LOAD);
    assign decoded_o.is_store = (opcode == OPC_STORE);
    assign decoded_o.illegal  = (decoded_o.op == INVALID);

    // A legal memory access decodes to an operation of its own kind
    always_comb begin
        if (!decoded_o.illegal && decoded_o.is_load) begin
            load_op_a: assert (decoded_o.op inside {LB, LBU, LH, LHU, LW});
        end
        if (!decoded_o.illegal && decoded_o.is_store) begin
            store_op_a: assert (decoded_o.op inside {SB, SH, SW});
        end
    end

endmodule

//--- source/operand_builder.sv
// Operand builder
// Extracts the immediate and selects the three operands for execute
module operand_builder
    import decode_pkg::*;
(
    input  logic [XLEN-1:0] instruction_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    input  decoded_t        decoded_i,
    output operands_t       operands_o,
    output logic            misaligned_o
);

    //////////////////////////////
    // Immediates
    //////////////////////////////
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] immediate;

    assign imm_i = {{21{instruction_i[31]}}, instruction_i[30:20]};
    assign imm_s = {{21{instruction_i[31]}}, instruction_i[30:25], instruction_i[11:7]};
    assign imm_b = {{20{instruction_i[31]}}, instruction_i[7], instruction_i[30:25],
                    instruction_i[11:8], 1'b0};
    assign imm_u = {instruction_i[31:12], 12'b0};
    assign imm_j = {{12{instruction_i[31]}}, instruction_i[19:12], instruction_i[20],
                    instruction_i[30:21], 1'b0};

    always_comb begin
        unique case (decoded_i.format)
            I_TYPE:  immediate = imm_i;
            S_TYPE:  immediate = imm_s;
            B_TYPE:  immediate = imm_b;
            U_TYPE:  immediate = imm_u;
            J_TYPE:  immediate = imm_j;
            default: immediate = '0;
        endcase
    end

    //////////////////////////////
    // Operand selection
    //////////////////////////////
    // PC based for AUIPC and JAL
    assign operands_o.first = (decoded_i.format inside {U_TYPE, J_TYPE}) ? pc_i : rs1_data_i;

    assign operands_o.second = (decoded_i.format inside {R_TYPE, B_TYPE}) ? rs2_data_i
                                                                          : immediate;

    // Store data rides in the third slot, offset in the second
    assign operands_o.third = (decoded_i.format == S_TYPE) ? rs2_data_i : immediate;

    // No compressed support, so fetch must be word aligned
    assign misaligned_o = |pc_i[1:0];

endmodule

//--- source/hazard_unit.sv
// Hazard unit
// Locks the destination of the last accepted instruction and requests bubbles
module hazard_unit
    import decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  enable_i,
    input  logic                  rollback_i,
    input  logic [XLEN-1:0]       instruction_i,
    input  decoded_t              decoded_i,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic                  hazard_o
);

    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] locked_rd;
    logic                  locked_store;
    logic                  hazard_rs1;
    logic                  hazard_rs2;
    logic                  hazard_mem;

    // Register bank addresses go out in the same cycle
    assign rs1_o = instruction_i[19:15];
    assign rs2_o = instruction_i[24:20];
    assign rd    = instruction_i[11:7];

    //////////////////////////////
    // Lock state
    //////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            locked_rd    <= '0;
            locked_store <= 1'b0;
        end else if (hazard_o) begin
            // Bubble goes out, nothing new is in flight
            locked_rd    <= '0;
            locked_store <= 1'b0;
        end else if (enable_i) begin
            locked_rd    <= rd;
            locked_store <= decoded_i.is_store;
        end
    end

    //////////////////////////////
    // Compare
    //////////////////////////////
    // x0 never matches
    assign hazard_rs1 = decoded_i.use_rs1 && (rs1_o != '0) && (rs1_o == locked_rd);
    assign hazard_rs2 = decoded_i.use_rs2 && (rs2_o != '0) && (rs2_o == locked_rd);
    assign hazard_mem = decoded_i.is_load && locked_store;

    assign hazard_o = (hazard_rs1 || hazard_rs2 || hazard_mem) && enable_i && !rollback_i;

    // The bubble clears the lock, so a request never repeats back to back
    single_bubble_a: assert property (
        @(posedge clk) disable iff (!reset_n) hazard_o |=> !hazard_o
    );

endmodule

//--- source/issue_register.sv
// Issue register
// Registers the decoded payload toward execute, with bubbles on hazard or rollback
module issue_register
    import decode_pkg::*;
(
    input  logic             clk,
    input  logic             reset_n,
    input  logic             enable_i,
    input  logic             rollback_i,
    input  logic             hazard_i,
    input  decoded_t         decoded_i,
    input  operands_t        operands_i,
    input  logic [XLEN-1:0]  instruction_i,
    input  logic [XLEN-1:0]  pc_i,
    input  logic [TAG_W-1:0] tag_i,
    input  logic             misaligned_i,
    input  logic             access_fault_i,
    output issue_t           issue_o
);

    logic   kill;
    issue_t payload;
    issue_t bubble;

    assign kill = hazard_i || rollback_i;

    always_comb begin
        payload.op           = decoded_i.op;
        payload.rd           = instruction_i[11:7];
        payload.first        = operands_i.first;
        payload.second       = operands_i.second;
        payload.third        = operands_i.third;
        payload.pc           = pc_i;
        payload.tag          = tag_i;
        payload.illegal      = decoded_i.illegal;
        payload.misaligned   = misaligned_i;
        payload.access_fault = access_fault_i;
    end

    // Bubble keeps the tag so execute can match the slot
    always_comb begin
        bubble     = '0;
        bubble.op  = NOP;
        bubble.tag = tag_i;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            issue_o <= '0;
        end else if (kill) begin
            issue_o <= bubble;
        end else if (enable_i) begin
            issue_o <= payload;
        end
    end

    bubble_after_kill_a: assert property (
        @(posedge clk) disable iff (!reset_n) kill |=> (issue_o.op == NOP)
    );

endmodule

//--- source/decode_stage.sv
// RV32I decode stage
// Decodes one instruction per cycle and registers it toward execute
module decode_stage
    import decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  enable_i,
    input  logic [XLEN-1:0]       instruction_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [TAG_W-1:0]      tag_i,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    input  logic                  rollback_i,
    input  logic                  access_fault_i,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic                  hazard_o,
    output issue_t                issue_o
);

    decoded_t  decoded;
    operands_t operands;
    logic      misaligned;

    op_decoder op_decoder_i (
        .instruction_i (instruction_i),
        .decoded_o     (decoded)
    );

    operand_builder operand_builder_i (
        .instruction_i (instruction_i),
        .pc_i          (pc_i),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .decoded_i     (decoded),
        .operands_o    (operands),
        .misaligned_o  (misaligned)
    );

    hazard_unit hazard_unit_i (
        .clk           (clk),
        .reset_n       (reset_n),
        .enable_i      (enable_i),
        .rollback_i    (rollback_i),
        .instruction_i (instruction_i),
        .decoded_i     (decoded),
        .rs1_o         (rs1_o),
        .rs2_o         (rs2_o),
        .hazard_o      (hazard_o)
    );

    issue_register issue_register_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .enable_i       (enable_i),
        .rollback_i     (rollback_i),
        .hazard_i       (hazard_o),
        .decoded_i      (decoded),
        .operands_i     (operands),
        .instruction_i  (instruction_i),
        .pc_i           (pc_i),
        .tag_i          (tag_i),
        .misaligned_i   (misaligned),
        .access_fault_i (access_fault_i),
        .issue_o        (issue_o)
    );

endmodule

//--- sim/decode_stage_tb.sv
// Testbench for the RV32I decode stage
// Replays the case file cycle by cycle and checks hazard_o and issue_o
module decode_stage_tb
    import decode_pkg::*;
();

    localparam string CASE_FILE    = "sim/decode_cases.txt";
    localparam int    SEED         = 40510;
    localparam int    RESET_CYCLES = 10;
    localparam int    MAX_LINES    = 1000;
    localparam int    MAX_CYCLES   = 500;
    localparam int    FIELDS       = 17;

    // One line of the case file, stimulus first, then expected values
    typedef struct packed {
        logic                  enable;
        logic                  rollback;
        logic                  access_fault;
        logic [XLEN-1:0]       instruction;
        logic [XLEN-1:0]       pc;
        logic [TAG_W-1:0]      tag;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic                  hazard;
        logic [5:0]            op;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       first;
        logic [XLEN-1:0]       second;
        logic [XLEN-1:0]       third;
        logic                  illegal;
        logic                  misaligned;
        logic                  fault;
    } case_t;

    logic                  clk;
    logic                  reset_n;
    logic                  enable_i;
    logic [XLEN-1:0]       instruction_i;
    logic [XLEN-1:0]       pc_i;
    logic [TAG_W-1:0]      tag_i;
    logic [XLEN-1:0]       rs1_data_i;
    logic [XLEN-1:0]       rs2_data_i;
    logic                  rollback_i;
    logic                  access_fault_i;
    logic [REG_ADDR_W-1:0] rs1_o;
    logic [REG_ADDR_W-1:0] rs2_o;
    logic                  hazard_o;
    issue_t                issue_o;

    case_t cases[$];
    int    errors;
    int    checks;

    decode_stage dut_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .enable_i       (enable_i),
        .instruction_i  (instruction_i),
        .pc_i           (pc_i),
        .tag_i          (tag_i),
        .rs1_data_i     (rs1_data_i),
        .rs2_data_i     (rs2_data_i),
        .rollback_i     (rollback_i),
        .access_fault_i (access_fault_i),
        .rs1_o          (rs1_o),
        .rs2_o          (rs2_o),
        .hazard_o       (hazard_o),
        .issue_o        (issue_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////
    task automatic read_cases();
        int          fd;
        int          count;
        int          line_no;
        string       line;
        logic [31:0] f [0:16];
        case_t       c;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the case file %s", CASE_FILE);
            errors++;
            return;
        end
        line_no = 0;
        while (line_no < MAX_LINES && $fgets(line, fd) != 0) begin
            line_no++;
            // Skip blank lines and the column header
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                            f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
            if (count != FIELDS) begin
                $display("Case line %0d has %0d fields instead of %0d", line_no, count, FIELDS);
                errors++;
            end else begin
                c = {f[0][0], f[1][0], f[2][0], f[3], f[4], f[5][TAG_W-1:0], f[6], f[7],
                     f[8][0], f[9][5:0], f[10][REG_ADDR_W-1:0], f[11], f[12], f[13],
                     f[14][0], f[15][0], f[16][0]};
                cases.push_back(c);
            end
        end
        $fclose(fd);
        if (cases.size() == 0) begin
            $display("The case file holds no cases");
            errors++;
        end
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic drive_case(case_t c);
        enable_i       = c.enable;
        rollback_i     = c.rollback;
        access_fault_i = c.access_fault;
        instruction_i  = c.instruction;
        pc_i           = c.pc;
        tag_i          = c.tag;
        // Register data is dropped on bubble cycles
        if (c.hazard || c.rollback) begin
            rs1_data_i = $urandom;
            rs2_data_i = $urandom;
        end else begin
            rs1_data_i = c.rs1_data;
            rs2_data_i = c.rs2_data;
        end
    endtask

    task automatic check_issue(case_t c, logic [XLEN-1:0] pc, logic [TAG_W-1:0] tag);
        check_value("issue_o.op", c.op, issue_o.op);
        check_value("issue_o.rd", c.rd, issue_o.rd);
        check_value("issue_o.first", c.first, issue_o.first);
        check_value("issue_o.second", c.second, issue_o.second);
        check_value("issue_o.third", c.third, issue_o.third);
        check_value("issue_o.pc", pc, issue_o.pc);
        check_value("issue_o.tag", tag, issue_o.tag);
        check_value("issue_o.illegal", c.illegal, issue_o.illegal);
        check_value("issue_o.misaligned", c.misaligned, issue_o.misaligned);
        check_value("issue_o.access_fault", c.fault, issue_o.access_fault);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        int               idx;
        int               cycles;
        logic             timed_out;
        logic [XLEN-1:0]  expected_pc;
        logic [TAG_W-1:0] expected_tag;
        case_t            c;
        void'($urandom(SEED));
        errors         = 0;
        checks         = 0;
        reset_n        = 1'b0;
        enable_i       = 1'b0;
        rollback_i     = 1'b0;
        access_fault_i = 1'b0;
        instruction_i  = '0;
        pc_i           = '0;
        tag_i          = '0;
        rs1_data_i     = '0;
        rs2_data_i     = '0;
        read_cases();

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
        end
        #10;
        reset_n = 1'b1;
        checks++;
        if (issue_o !== '0) begin
            errors++;
            $display("** Error at %0t: issue_o expected 0, got %h", $time, issue_o);
        end
        check_value("hazard_o", 1'b0, hazard_o);

        // One case per cycle, inputs land 10 units after the edge
        idx          = 0;
        cycles       = 0;
        timed_out    = 1'b0;
        expected_pc  = '0;
        expected_tag = '0;
        while (idx < cases.size() && !timed_out) begin
            c = cases[idx];
            drive_case(c);
            #80;
            check_value("hazard_o", c.hazard, hazard_o);
            check_value("rs1_o", c.instruction[19:15], rs1_o);
            check_value("rs2_o", c.instruction[24:20], rs2_o);
            // Bubbles carry the new tag and a zero PC, a disabled cycle holds the slot
            if (c.hazard || c.rollback) begin
                expected_pc  = '0;
                expected_tag = c.tag;
            end else if (c.enable) begin
                expected_pc  = c.pc;
                expected_tag = c.tag;
            end
            @(posedge clk);
            #10;
            check_issue(c, expected_pc, expected_tag);
            idx++;
            cycles++;
            if (cycles >= MAX_CYCLES && idx < cases.size()) begin
                $display("Timeout: the case loop stopped after %0d cycles", cycles);
                timed_out = 1'b1;
                errors++;
            end
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- sim/decode_cases.txt
# en rb af instr pc tag rs1_data rs2_data
# then expected: hazard op rd first second third illegal misaligned access_fault
1 0 0 002081B3 00001000 1 11111111 22222222 0 02 03 11111111 22222222 00000000 0 0 0
1 0 0 407302B3 00001004 2 0000000A 00000003 0 03 05 0000000A 00000003 00000000 0 0 0
1 0 0 FFB48413 00001008 3 00000100 00000200 0 02 08 00000100 FFFFFFFB FFFFFFFB 0 0 0
1 0 0 4045D513 0000100C 4 80000000 33333333 0 09 0A 80000000 00000404 00000404 0 0 0
1 0 0 ABCDE637 00001010 5 44444444 55555555 0 01 0C 00001010 ABCDE000 ABCDE000 0 0 0
1 0 0 00001697 00001014 6 44444444 55555555 0 02 0D 00001014 00001000 00001000 0 0 0
1 0 0 FF9FF0EF 00001018 7 44444444 55555555 0 0C 01 00001018 FFFFFFF8 FFFFFFF8 0 0 0
1 0 0 00C10067 0000101C 0 00002000 66666666 0 0D 00 00002000 0000000C 0000000C 0 0 0
1 0 0 FE2088E3 00001020 1 77777777 88888888 0 0E 11 77777777 88888888 FFFFFFF0 0 0 0
1 0 0 0081A703 00001024 2 00003000 99999999 0 18 0E 00003000 00000008 00000008 0 0 0
1 0 0 00532223 00001028 3 00004000 CAFEF00D 0 1B 04 00004000 00000004 CAFEF00D 0 0 0
1 0 0 00038783 0000102C 4 00000000 00000000 1 00 00 00000000 00000000 00000000 0 0 0
1 0 0 00038783 0000102C 4 00005000 12345678 0 14 0F 00005000 00000000 00000000 0 0 0
1 0 0 00241803 00001030 5 00006000 00000000 0 16 10 00006000 00000002 00000002 0 0 0
1 0 0 004808B3 00001034 6 00000000 00000000 1 00 00 00000000 00000000 00000000 0 0 0
1 0 0 004808B3 00001034 6 00000010 00000020 0 02 11 00000010 00000020 00000000 0 0 0
1 0 0 00000013 00001038 7 00000000 00000000 0 02 00 00000000 00000000 00000000 0 0 0
1 0 0 00000933 0000103C 0 00000000 00000000 0 02 12 00000000 00000000 00000000 0 0 0
1 0 0 FFFFFFFF 00001040 1 AAAA0000 0000BBBB 0 3F 1F AAAA0000 0000BBBB 00000000 1 0 0
1 0 0 40311193 00001044 2 01010101 02020202 0 3F 03 01010101 00000403 00000403 1 0 0
1 0 0 027302B3 00001048 3 00000006 00000007 0 3F 05 00000006 00000007 00000000 1 0 0
1 0 0 00000073 0000104C 4 00000000 00000000 0 1C 00 00000000 00000000 00000000 0 0 0
1 0 0 00100073 00001050 5 00000000 0BADBEEF 0 1D 00 00000000 0BADBEEF 00000000 0 0 0
1 0 0 30200073 00001054 6 00000000 00000022 0 1F 00 00000000 00000022 00000000 0 0 0
1 0 0 30029373 00001058 7 00001888 00000000 0 21 06 00001888 00000000 00000000 0 0 0
1 0 0 3051E3F3 0000105C 0 33330000 55550000 0 25 07 33330000 55550000 00000000 0 0 0
1 1 0 00138433 00001060 1 00000000 00000000 0 00 00 00000000 00000000 00000000 0 0 0
1 0 0 0F014493 00001064 2 0000FFFF 00000000 0 04 09 0000FFFF 000000F0 000000F0 0 0 0
0 0 0 0094E533 00001068 3 00F0F0F0 00F0F0F0 0 04 09 0000FFFF 000000F0 000000F0 0 0 0
1 0 0 0094E533 00001068 3 00000000 00000000 1 00 00 00000000 00000000 00000000 0 0 0
1 0 0 0094E533 00001068 3 00F0F0F0 00F0F0F0 0 05 0A 00F0F0F0 00F0F0F0 00000000 0 0 0
1 0 0 7FF67593 0000106E 4 12345678 00000000 0 06 0B 12345678 000007FF 000007FF 0 1 0
1 0 1 00F736B3 00001070 5 00000001 FFFFFFFF 0 0B 0D 00000001 FFFFFFFF 00000000 0 0 1
0 1 0 00000013 00001074 6 00000000 00000000 0 00 00 00000000 00000000 00000000 0 0 0
1 0 0 003120B3 00001074 7 FFFFFFFE 00000005 0 0A 01 FFFFFFFE 00000005 00000000 0 0 0
1 0 0 00110023 00001078 0 00000000 00000000 1 00 00 00000000 00000000 00000000 0 0 0
1 0 0 00110023 00001078 0 00008000 000000AB 0 19 00 00008000 00000000 000000AB 0 0 0
1 0 0 00410113 0000107C 1 00008000 00000000 0 02 02 00008000 00000004 00000004 0 0 0

//--- compile.f
source/decode_pkg.sv
source/op_decoder.sv
source/operand_builder.sv
source/hazard_unit.sv
source/issue_register.sv
source/decode_stage.sv
sim/decode_stage_tb.sv

//--- Makefile
TOP = decode_stage_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir

.PHONY: sim clean
